//--- icache.f
+incdir+.
icache_pkg.sv
sram_1p_rw.sv
icache_tag_array.sv
icache_data_array.sv
icache_line_fill.sv
icache_fsm.sv
icache.sv
icache_checker.sv
icache_tb.sv

//--- icache_ref.svh
/*
 * Backing memory contents for the instruction cache testbench
 * Each 32-bit word is its word address mixed with a fixed constant
 */

function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
  logic [31:0] word_addr;
  word_addr = byte_addr >> 2;
  // Odd multiplier keeps every word address distinct
  return (word_addr * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
endfunction

//--- icache_tb.sv
/*
 * Instruction cache testbench
 * Drives CPU requests and flushes on the falling edge, models the
 * backing memory with random beat gaps and bounds the run in cycles
 */

`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  // Requests over all five tests
  localparam int NUM_REQS     = 64 + 256 + 8 + 24 + 300;
  localparam int MAX_CYCLES   = NUM_REQS * 40 + RESET_CYCLES;
  localparam logic [15:0] SEED = 16'd5824;

  logic              clk;
  logic              rst_n;
  logic              cpu_req;
  icache_addr_t      cpu_addr;
  logic              flush;
  logic              cpu_valid;
  logic [WORD_W-1:0] cpu_rdata;
  logic              mem_req;
  logic [31:0]       mem_addr;
  logic              mem_rvalid;
  logic [WORD_W-1:0] mem_rdata;
  logic [2:0]        test_id;
  logic [31:0]       error_count;
  logic [31:0]       resp_count;
  logic [31:0]       miss_count;
  logic [15:0]       stim_lfsr;
  logic [15:0]       gap_lfsr;
  icache_state_e     fsm_view;
  int                issued;
  int                cycles;

  `include "icache_ref.svh"

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw(inout logic [15:0] s, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_step(s);
      v = {v[30:0], s[0]};
    end
  endtask

  function automatic logic [TAG_W-1:0] pool_tag(input logic [1:0] sel);
    return {sel, 20'hC35A1};
  endfunction

  function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                            input logic [INDEX_W-1:0] idx,
                                            input logic [OFFSET_W-1:0] off);
    return {tag, idx, off, 2'b00};
  endfunction

  // Starts on a falling edge and returns one edge after cpu_valid
  task automatic fetch(input logic [31:0] addr);
    cpu_req  = 1'b1;
    cpu_addr = addr;
    issued   = issued + 1;
    @(negedge clk);
    cpu_req = 1'b0;
    while (cpu_valid !== 1'b1) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic flush_all();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  icache dut_i (
    .clk (clk), .rst_n (rst_n), .cpu_req (cpu_req), .cpu_addr (cpu_addr),
    .flush (flush), .cpu_valid (cpu_valid), .cpu_rdata (cpu_rdata),
    .mem_req (mem_req), .mem_addr (mem_addr), .mem_rvalid (mem_rvalid),
    .mem_rdata (mem_rdata)
  );

  icache_checker checker_i (
    .clk (clk), .rst_n (rst_n), .cpu_req (cpu_req), .cpu_addr (cpu_addr),
    .flush (flush), .cpu_valid (cpu_valid), .cpu_rdata (cpu_rdata),
    .mem_req (mem_req), .mem_addr (mem_addr), .test_id (test_id),
    .error_count (error_count), .resp_count (resp_count), .miss_count (miss_count)
  );

  assign fsm_view = dut_i.fsm_state;

  // ******************************
  // Memory model with four beats per request
  // ******************************
  // Each beat follows 0 to 3 idle cycles
  initial begin : mem_model
    logic [31:0] line_addr;
    logic [31:0] gap;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    gap_lfsr   = SEED;
    forever begin
      @(negedge clk);
      if (mem_req === 1'b1) begin
        line_addr = mem_addr;
        // First beat no earlier than the cycle after the request
        @(negedge clk);
        for (int b = 0; b < BEATS; b++) begin
          draw(gap_lfsr, 2, gap);
          mem_rvalid = 1'b0;
          repeat (gap) @(negedge clk);
          mem_rvalid = 1'b1;
          mem_rdata  = expected_word(line_addr + 32'(4 * b));
          @(negedge clk);
        end
        mem_rvalid = 1'b0;
      end
    end
  end

  // ******************************
  // Test sequence
  // ******************************
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] sel;
    logic [31:0] idx;
    logic [31:0] off;
    rst_n     = 1'b0;
    cpu_req   = 1'b0;
    cpu_addr  = '0;
    flush     = 1'b0;
    test_id   = 3'd1;
    issued    = 0;
    stim_lfsr = SEED;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // Quiet cycles where any strobe is an error
    repeat (4) @(negedge clk);
    // Cold miss on every set
    for (int i = 0; i < NUM_SETS; i++) fetch(make_addr(pool_tag(0), i[5:0], i[1:0]));
    test_id = 3'd2;
    for (int i = 0; i < NUM_SETS; i++) begin
      for (int o = 0; o < BEATS; o++) fetch(make_addr(pool_tag(0), i[5:0], o[1:0]));
    end
    // Two tags fighting over set 5
    test_id = 3'd3;
    for (int k = 0; k < 4; k++) begin
      fetch(make_addr(pool_tag(1), 6'd5, k[1:0]));
      fetch(make_addr(pool_tag(2), 6'd5, ~k[1:0]));
    end
    // Fill, flush, refill, then hit
    test_id = 3'd4;
    for (int i = 0; i < 8; i++) fetch(make_addr(pool_tag(3), 6'd10 + i[5:0], i[1:0]));
    flush_all();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 8; i++) fetch(make_addr(pool_tag(3), 6'd10 + i[5:0], i[1:0]));
    end
    test_id = 3'd5;
    for (int n = 0; n < 300; n++) begin
      draw(stim_lfsr, 4, r);
      if (r == 0) flush_all();
      draw(stim_lfsr, 2, sel);
      draw(stim_lfsr, 6, idx);
      draw(stim_lfsr, 2, off);
      fetch(make_addr(pool_tag(sel[1:0]), idx[5:0], off[1:0]));
    end
    repeat (4) @(negedge clk);
    $display("Requests %0d, responses %0d, misses %0d, errors %0d",
             issued, resp_count, miss_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run limit of 40 cycles per request plus reset
  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout after %0d cycles with the controller in state %s",
             cycles, fsm_view.name());
    $display("Requests %0d, responses %0d, misses %0d, errors %0d",
             issued, resp_count, miss_count, error_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_checker.sv
/*
 * Instruction cache checker
 * Watches the CPU and memory ports, predicts hits from a shadow
 * tag table and compares data, fetch address, fetch count and latency
 */

`timescale 1ns/1ps
`default_nettype none

module icache_checker
  import icache_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              cpu_req,
  input  wire icache_addr_t      cpu_addr,
  input  wire logic              flush,
  input  wire logic              cpu_valid,
  input  wire logic [WORD_W-1:0] cpu_rdata,
  input  wire logic              mem_req,
  input  wire logic [31:0]       mem_addr,
  input  wire logic [2:0]        test_id,
  output logic      [31:0]       error_count,
  output logic      [31:0]       resp_count,
  output logic      [31:0]       miss_count
);

  `include "icache_ref.svh"

  // Shadow copy of the tag array
  logic [TAG_W-1:0]    sh_tag [NUM_SETS];
  logic [NUM_SETS-1:0] sh_valid;

  // Outstanding request
  logic         pending;
  icache_addr_t req_addr;
  logic         want_miss;
  int           mem_cnt;
  int           cyc;
  int           req_cyc;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "cold_miss";
      3'd2: return "hit_offsets";
      3'd3: return "evict_same_index";
      3'd4: return "flush_refill";
      default: return "random_mix";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail %s %s expected %h actual %h", test_name(test_id), what, exp, act);
    error_count = error_count + 1;
  endtask

  initial begin
    error_count = 0;
    resp_count  = 0;
    miss_count  = 0;
    cyc         = 0;
    pending     = 1'b0;
    sh_valid    = '0;
  end

  // ******************************
  // Port monitor, sampled at the rising edge
  // ******************************
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      sh_valid = '0;
      pending  = 1'b0;
    end else begin
      // Idle cache must keep both strobes low
      if (!pending && (cpu_valid !== 1'b0 || mem_req !== 1'b0)) begin
        $display("Error in %s: strobe active with no request outstanding at cycle %0d",
                 test_name(test_id), cyc);
        error_count = error_count + 1;
      end
      if (pending && mem_req === 1'b1) begin
        mem_cnt = mem_cnt + 1;
        if (mem_addr !== (req_addr & 32'hFFFF_FFF0)) begin
          report_mismatch("mem_addr", req_addr & 32'hFFFF_FFF0, mem_addr);
        end
      end
      if (pending && cpu_valid === 1'b1) begin
        if (cpu_rdata !== expected_word(req_addr)) begin
          report_mismatch("cpu_rdata", expected_word(req_addr), cpu_rdata);
        end
        // A miss fetches exactly once, a hit never
        if (mem_cnt != (want_miss ? 1 : 0)) begin
          report_mismatch("mem_req count", want_miss ? 1 : 0, mem_cnt);
        end
        if (!want_miss && (cyc - req_cyc) != 1) begin
          report_mismatch("hit latency", 1, cyc - req_cyc);
        end
        sh_valid[req_addr.index] = 1'b1;
        sh_tag[req_addr.index]   = req_addr.tag;
        resp_count = resp_count + 1;
        if (want_miss) begin
          miss_count = miss_count + 1;
        end
        pending = 1'b0;
      end
      if (flush === 1'b1) begin
        sh_valid = '0;
      end else if (cpu_req === 1'b1) begin
        pending   = 1'b1;
        req_addr  = cpu_addr;
        req_cyc   = cyc;
        mem_cnt   = 0;
        want_miss = !(sh_valid[cpu_addr.index] && sh_tag[cpu_addr.index] == cpu_addr.tag);
      end
    end
  end

endmodule

`default_nettype wire

//--- icache.sv
/*
 * Read-only instruction cache, top level
 * Direct-mapped, 64 sets of 16-byte lines
 * Ties the controller, tag array, data array and fill buffer
 * to the CPU and memory strobe ports
 */

`timescale 1ns/1ps
`default_nettype none

module icache
  import icache_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  // CPU side
  input  wire logic              cpu_req,
  input  wire icache_addr_t      cpu_addr,
  input  wire logic              flush,
  output logic                   cpu_valid,
  output logic      [WORD_W-1:0] cpu_rdata,
  // Memory side
  output logic                   mem_req,
  output logic      [31:0]       mem_addr,
  input  wire logic              mem_rvalid,
  input  wire logic [WORD_W-1:0] mem_rdata
);

  // Controller to arrays
  logic               array_ce;
  logic               array_we;
  logic [INDEX_W-1:0] array_index;
  icache_addr_t       lookup_addr;
  // Status back to the controller
  logic               hit;
  logic               line_done;
  // Fill path
  logic               fill_start;
  line_t              fill_line;
  // Debug view of the controller
  icache_state_e      fsm_state;

  // ******************************
  // Controller
  // ******************************
  icache_fsm fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_req     (cpu_req),
    .cpu_addr    (cpu_addr),
    .flush       (flush),
    .hit         (hit),
    .line_done   (line_done),
    .cpu_valid   (cpu_valid),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .fill_start  (fill_start),
    .array_ce    (array_ce),
    .array_we    (array_we),
    .array_index (array_index),
    .lookup_addr (lookup_addr),
    .state       (fsm_state)
  );

  // ******************************
  // Arrays
  // ******************************
  icache_tag_array tag_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .array_ce    (array_ce),
    .array_we    (array_we),
    .array_index (array_index),
    .lookup_addr (lookup_addr),
    .flush       (flush),
    .hit         (hit)
  );

  icache_data_array data_i (
    .clk         (clk),
    .array_ce    (array_ce),
    .array_we    (array_we),
    .array_index (array_index),
    .fill_line   (fill_line),
    .lookup_addr (lookup_addr),
    .cpu_rdata   (cpu_rdata)
  );

  // Beat collection from memory
  icache_line_fill fill_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill_start (fill_start),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .fill_line  (fill_line),
    .line_done  (line_done)
  );

endmodule

`default_nettype wire

//--- icache_fsm.sv
/*
 * Instruction cache controller
 * Accepts CPU requests, checks for a hit, fetches a missing line,
 * writes it into the arrays and re-reads them to return the word
 * Flush is only taken in READY
 */

`timescale 1ns/1ps
`default_nettype none

module icache_fsm
  import icache_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               cpu_req,
  input  wire icache_addr_t       cpu_addr,
  input  wire logic               flush,
  input  wire logic               hit,
  input  wire logic               line_done,
  output logic                    cpu_valid,
  output logic                    mem_req,
  output logic      [31:0]        mem_addr,
  output logic                    fill_start,
  output logic                    array_ce,
  output logic                    array_we,
  output logic      [INDEX_W-1:0] array_index,
  output icache_addr_t            lookup_addr,
  output icache_state_e           state
);

  icache_state_e state_nxt;

  // Request taken this cycle, flush wins
  logic accept;

  assign accept = (state == READY) && cpu_req && !flush;

  // ******************************
  // State register
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= READY;
    end else begin
      state <= state_nxt;
    end
  end

  // Held request address
  always_ff @(posedge clk) begin
    if (accept) begin
      lookup_addr <= cpu_addr;
    end
  end

  // Next state
  always_comb begin
    state_nxt = state;
    unique case (state)
      READY:      if (accept) state_nxt = LOOKUP;
      // Either return the word or go fetch the line
      LOOKUP:     state_nxt = hit ? READY : MISS_REQ;
      MISS_REQ:   state_nxt = FILL;
      FILL:       if (line_done) state_nxt = WRITE_LINE;
      WRITE_LINE: state_nxt = REREAD;
      // Re-read lands back in LOOKUP, which then hits
      REREAD:     state_nxt = LOOKUP;
      default:    state_nxt = READY;
    endcase
  end

  // ******************************
  // Outputs
  // ******************************
  assign cpu_valid  = (state == LOOKUP) && hit;
  assign mem_req    = (state == MISS_REQ);
  // Fill buffer restarts with the memory request
  assign fill_start = (state == MISS_REQ);
  // Line-aligned fetch address
  assign mem_addr   = {lookup_addr.tag, lookup_addr.index, 4'b0000};

  // Arrays are enabled on lookup, line write and re-read
  assign array_ce = accept || (state == WRITE_LINE) || (state == REREAD);
  assign array_we = (state == WRITE_LINE);

  // Live index in READY, held index otherwise
  assign array_index = (state == READY) ? cpu_addr.index : lookup_addr.index;

endmodule

`default_nettype wire

//--- icache_line_fill.sv
/*
 * Line fill buffer
 * Collects four memory beats, word 0 first, into one line
 * and flags the line as complete after the last beat
 */

`timescale 1ns/1ps
`default_nettype none

module icache_line_fill
  import icache_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              fill_start,
  input  wire logic              mem_rvalid,
  input  wire logic [WORD_W-1:0] mem_rdata,
  output line_t                  fill_line,
  output logic                   line_done
);

  // Slot for the next beat
  logic [$clog2(BEATS)-1:0] beat_cnt;

  // Beat counter and done flag
  always_ff @(posedge clk) begin
    if (!rst_n || fill_start) begin
      beat_cnt  <= '0;
      line_done <= 1'b0;
    end else if (mem_rvalid) begin
      beat_cnt <= beat_cnt + 1'b1;
      // Last beat completes the line, counter wraps to 0
      if (beat_cnt == BEATS - 1) begin
        line_done <= 1'b1;
      end
    end
  end

  // Line buffer, payload only
  always_ff @(posedge clk) begin
    if (mem_rvalid) begin
      unique case (beat_cnt)
        2'd0: fill_line.w0 <= mem_rdata;
        2'd1: fill_line.w1 <= mem_rdata;
        2'd2: fill_line.w2 <= mem_rdata;
        2'd3: fill_line.w3 <= mem_rdata;
        default: fill_line.w0 <= mem_rdata;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- icache_data_array.sv
/*
 * Instruction cache data array
 * Holds whole 128-bit lines and picks the requested
 * 32-bit word out of the line read back
 */

`timescale 1ns/1ps
`default_nettype none

module icache_data_array
  import icache_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               array_ce,
  input  wire logic               array_we,
  input  wire logic [INDEX_W-1:0] array_index,
  input  wire line_t              fill_line,
  input  wire icache_addr_t       lookup_addr,
  output logic      [WORD_W-1:0]  cpu_rdata
);

  // Raw line from the RAM
  logic [LINE_W-1:0] line_rd;
  line_t             line_sel;

  // Line RAM, written only from the fill buffer
  sram_1p_rw #(
    .DEPTH (NUM_SETS),
    .WIDTH (LINE_W)
  ) data_ram_i (
    .clk  (clk),
    .ce   (array_ce),
    .addr (array_index),
    .din  (fill_line),
    .we   (array_we),
    .dout (line_rd)
  );

  assign line_sel = line_t'(line_rd);

  // ******************************
  // Word select by offset
  // ******************************
  always_comb begin
    unique case (lookup_addr.offset)
      2'd0: cpu_rdata = line_sel.w0;
      2'd1: cpu_rdata = line_sel.w1;
      2'd2: cpu_rdata = line_sel.w2;
      2'd3: cpu_rdata = line_sel.w3;
      default: cpu_rdata = line_sel.w0;
    endcase
  end

endmodule

`default_nettype wire

//--- icache_tag_array.sv
/*
 * Instruction cache tag array
 * Tag RAM plus one valid bit per set, cleared on reset or flush
 * Produces the hit flag for the held request address
 */

`timescale 1ns/1ps
`default_nettype none

module icache_tag_array
  import icache_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               array_ce,
  input  wire logic               array_we,
  input  wire logic [INDEX_W-1:0] array_index,
  input  wire icache_addr_t       lookup_addr,
  input  wire logic               flush,
  output logic                    hit
);

  // Tag read out of the RAM for the last enabled index
  logic [TAG_W-1:0] tag_rd;

  // One valid bit per set
  logic [NUM_SETS-1:0] valid;

  // ******************************
  // Tag storage
  // ******************************
  sram_1p_rw #(
    .DEPTH (NUM_SETS),
    .WIDTH (TAG_W)
  ) tag_ram_i (
    .clk  (clk),
    .ce   (array_ce),
    .addr (array_index),
    // New tag always comes from the held request
    .din  (lookup_addr.tag),
    .we   (array_we),
    .dout (tag_rd)
  );

  // ******************************
  // Valid bits
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      // Flush drops every line at once
      valid <= '0;
    end else if (array_ce && array_we) begin
      // Line write makes the set valid
      valid[array_index] <= 1'b1;
    end
  end

  // Hit needs a valid set and a matching tag
  assign hit = valid[lookup_addr.index] && (tag_rd == lookup_addr.tag);

endmodule

`default_nettype wire

//--- sram_1p_rw.sv
/*
 * Single-port synchronous RAM, read/write, no byte enables
 * Address is registered on an enabled edge and the read word
 * follows combinationally from that registered address
 * Writes need both ce and we high
 */

`timescale 1ns/1ps
`default_nettype none

module sram_1p_rw #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 22
) (
  input  wire logic                     clk,
  input  wire logic                     ce,
  input  wire logic [$clog2(DEPTH)-1:0] addr,
  input  wire logic [WIDTH-1:0]         din,
  input  wire logic                     we,
  output logic      [WIDTH-1:0]         dout
);

  // Storage array, contents undefined after power up
  logic [WIDTH-1:0] mem [DEPTH];

  // Read address captured whenever the RAM is enabled
  logic [$clog2(DEPTH)-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (ce) begin
      addr_q <= addr;
    end
  end

  // Read data holds until the next enabled edge
  assign dout = mem[addr_q];

  // Write port
  always_ff @(posedge clk) begin
    if (ce && we) begin
      mem[addr] <= din;
    end
  end

endmodule

`default_nettype wire

//--- icache_pkg.sv
/*
 * Instruction cache shared definitions
 * Geometry of the direct-mapped cache, the request address split,
 * the line layout and the controller state encoding
 */

`default_nettype none

package icache_pkg;

  // ******************************
  // Cache geometry
  // ******************************
  localparam int NUM_SETS = 64;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = 22;
  // Word offset within a line
  localparam int OFFSET_W = 2;
  localparam int WORD_W   = 32;
  localparam int BEATS    = 4;
  localparam int LINE_W   = 128;

  // Byte address as seen by the CPU, tag at the top
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic [1:0]          byte_off;
  } icache_addr_t;

  // One cache line, word 0 in the low bits
  typedef struct packed {
    logic [WORD_W-1:0] w3;
    logic [WORD_W-1:0] w2;
    logic [WORD_W-1:0] w1;
    logic [WORD_W-1:0] w0;
  } line_t;

  // ******************************
  // Controller states
  // ******************************
  typedef enum logic [2:0] {
    READY,
    LOOKUP,
    MISS_REQ,
    FILL,
    WRITE_LINE,
    REREAD
  } icache_state_e;

endpackage

`default_nettype wire
